// ==== fetch_pkg.sv ====
/* shared widths, instruction encodings and the fetch queue entry
   imported by the fetch front end and its testbench */
`default_nettype none

package fetch_pkg;

	// data and address width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] instr_t;
	typedef logic [xlen-1:0] addr_t;

	// one queue slot, instruction word with the pc it was fetched from
	typedef struct packed {
		instr_t instr;
		addr_t  pc;
	} fetch_entry_t;

	// addi x0, x0, 0
	localparam instr_t nop_instr = 32'h0000_0013;

	// system opcode with all other fields zero
	localparam instr_t ecall_instr = 32'h0000_0073;

	// reverse the four bytes of a word
	function automatic logic [xlen-1:0] swap_bytes(input logic [xlen-1:0] word);
		logic [xlen-1:0] swapped;
		swapped = {word[7:0], word[15:8], word[23:16], word[31:24]};
		return swapped;
	endfunction

endpackage

`default_nettype wire

// ==== axil_read_master.sv ====
/* single outstanding AXI-Lite read master
   one rd_req level starts a read, rd_done pulses once with the word */
`timescale 1ns/1ns
`default_nettype none

module axil_read_master (
	input  wire logic           clk,
	input  wire logic           rst_n,

	// request side
	input  wire logic           rd_req,
	input  wire fetch_pkg::addr_t  rd_addr,
	output fetch_pkg::instr_t   rd_data,
	output logic                rd_done,

	// AXI-Lite read channels
	output fetch_pkg::addr_t    araddr,
	output logic                arvalid,
	input  wire logic           arready,
	input  wire fetch_pkg::instr_t rdata,
	input  wire logic           rvalid,
	output logic                rready
);

	typedef enum logic [1:0] {
		m_idle,
		m_addr,
		m_data
	} mstate_t;

	mstate_t state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= m_idle;
			arvalid <= 1'b0;
			rready  <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			case (state)
				m_idle: begin
					if (rd_req) begin
						arvalid <= 1'b1;
						state   <= m_addr;
					end
				end
				// hold arvalid until the slave takes the address
				m_addr: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= m_data;
					end
				end
				m_data: begin
					if (rvalid && rready) begin
						rready  <= 1'b0;
						rd_done <= 1'b1;
						state   <= m_idle;
					end
				end
				default: state <= m_idle;
			endcase
		end
	end

	// address and returned word
	always_ff @(posedge clk) begin
		if (state == m_idle && rd_req)
			araddr <= rd_addr;
		if (state == m_data && rvalid && rready)
			rd_data <= rdata;
	end

endmodule

`default_nettype wire

// ==== instr_queue.sv ====
/* synchronous FIFO carrying any packed payload type
   clear empties it in one cycle; almost_full marks depth minus 2 entries */
`timescale 1ns/1ns
`default_nettype none

module instr_queue #(
	parameter type payload_t  = logic [31:0],
	parameter int  DEPTH_LOG2 = 3
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic clear,
	input  wire logic wr_en,
	input  wire payload_t wr_data,
	input  wire logic rd_en,
	output payload_t  rd_data,
	output logic      empty,
	output logic      almost_full
);

	localparam int depth = 1 << DEPTH_LOG2;

	payload_t mem [depth];

	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   count;
	logic full;
	logic push;
	logic pop;

	assign full        = (count == (DEPTH_LOG2 + 1)'(depth));
	assign empty       = (count == '0);
	assign almost_full = (count >= (DEPTH_LOG2 + 1)'(depth - 2));

	// pushes when full and pops when empty are dropped
	assign push = wr_en && !full;
	assign pop  = rd_en && !empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	// head is visible without a read latency
	assign rd_data = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
/* instruction fetch unit: pc, fetch control FSM and the instruction queue
   reads one word at a time over AXI-Lite and issues them with their pc */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
	parameter int QUEUE_DEPTH_LOG2 = 3,
	parameter bit SWAP_BYTES       = 1'b1
) (
	input  wire logic              clk,
	input  wire logic              rst_n,

	// control from the core and debugger
	input  wire logic              go,
	input  wire fetch_pkg::addr_t  boot_pc,
	input  wire logic              stall,
	input  wire logic              flush,
	input  wire fetch_pkg::addr_t  redirect_pc,
	input  wire logic              ecall_retired,

	// issue to decode
	output fetch_pkg::instr_t      instr,
	output fetch_pkg::addr_t       pc_out,
	output logic                   instr_valid,

	// AXI-Lite read channels
	output fetch_pkg::addr_t       araddr,
	output logic                   arvalid,
	input  wire logic              arready,
	input  wire fetch_pkg::instr_t rdata,
	input  wire logic              rvalid,
	output logic                   rready
);

	import fetch_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_stall,
		st_ecall_wait
	} state_t;

	state_t state;
	state_t nxt_state;

	addr_t  pc;
	addr_t  pc_p4;
	addr_t  saved_pc;
	logic   outstanding;
	logic   flush_pending;
	logic   flush_pending_q;

	logic   rd_req;
	logic   rd_done;
	instr_t rd_data;
	logic   accept_word;
	instr_t fetched_word;
	logic   is_ecall;

	fetch_entry_t wr_entry;
	fetch_entry_t head_entry;
	instr_t       head_word;
	logic         q_empty;
	logic         q_almost_full;

	assign pc_p4 = pc + addr_t'(4);

	// a flush in the same cycle or a pending one throws the word away
	assign accept_word  = rd_done && !flush && !flush_pending;
	assign fetched_word = SWAP_BYTES ? swap_bytes(rd_data) : rd_data;
	assign is_ecall     = accept_word && (fetched_word == ecall_instr);

	// one read at a time, never in the flush cycle itself
	assign rd_req = (state == st_fetch) && !outstanding && !flush;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= nxt_state;
	end

	always_comb begin
		nxt_state = state;
		case (state)
			st_idle: begin
				if (go)
					nxt_state = st_fetch;
			end
			// ecall wins over a nearly full queue
			st_fetch: begin
				if (is_ecall)
					nxt_state = st_ecall_wait;
				else if (accept_word && q_almost_full)
					nxt_state = st_stall;
			end
			st_stall: begin
				if (!q_almost_full)
					nxt_state = st_fetch;
			end
			st_ecall_wait: begin
				if (ecall_retired)
					nxt_state = st_idle;
			end
			default: nxt_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			outstanding <= 1'b0;
		else if (rd_req)
			outstanding <= 1'b1;
		else if (rd_done)
			outstanding <= 1'b0;
	end

	// flush while a read is in flight waits for its rd_done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_pending   <= 1'b0;
			flush_pending_q <= 1'b0;
		end else begin
			if (flush && outstanding && !rd_done)
				flush_pending <= 1'b1;
			else if (rd_done)
				flush_pending <= 1'b0;
			flush_pending_q <= flush_pending;
		end
	end

	always_ff @(posedge clk) begin
		if (flush)
			saved_pc <= redirect_pc;
	end

	// pc stays on the request address until its rd_done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= boot_pc;
		else if (flush && (!outstanding || rd_done))
			pc <= redirect_pc;
		else if (rd_done)
			pc <= flush_pending ? saved_pc : pc_p4;
	end

	assign wr_entry = '{instr: rd_data, pc: pc};

	axil_read_master u_read_master (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_req  (rd_req),
		.rd_addr (pc),
		.rd_data (rd_data),
		.rd_done (rd_done),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	instr_queue #(
		.payload_t  (fetch_entry_t),
		.DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
	) u_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.clear       (flush),
		.wr_en       (accept_word),
		.wr_data     (wr_entry),
		.rd_en       (instr_valid),
		.rd_data     (head_entry),
		.empty       (q_empty),
		.almost_full (q_almost_full)
	);

	// memory words are little-endian when SWAP_BYTES is set
	assign head_word = SWAP_BYTES ? swap_bytes(head_entry.instr) : head_entry.instr;

	assign instr_valid = !q_empty && !stall && !flush && !flush_pending && !flush_pending_q;
	assign instr       = instr_valid ? head_word : nop_instr;
	assign pc_out      = instr_valid ? head_entry.pc : '0;

endmodule

`default_nettype wire

// ==== axil_instr_rom.sv ====
/* AXI-Lite read-only instruction memory with a fixed response delay
   preloaded word by word through the load port */
`timescale 1ns/1ns
`default_nettype none

module axil_instr_rom #(
	parameter int MEM_WORDS_LOG2 = 8,
	parameter int RESP_DELAY     = 2
) (
	input  wire logic                      clk,
	input  wire logic                      rst_n,

	// preload port
	input  wire logic                      load_en,
	input  wire logic [MEM_WORDS_LOG2-1:0] load_addr,
	input  wire fetch_pkg::instr_t         load_data,

	// AXI-Lite read channels
	input  wire fetch_pkg::addr_t          araddr,
	input  wire logic                      arvalid,
	output logic                           arready,
	output fetch_pkg::instr_t              rdata,
	output logic                           rvalid,
	input  wire logic                      rready
);

	import fetch_pkg::*;

	localparam int cnt_w = (RESP_DELAY > 0) ? $clog2(RESP_DELAY + 1) : 1;

	instr_t mem [1 << MEM_WORDS_LOG2];

	logic                      busy;
	logic [cnt_w-1:0]          delay_cnt;
	logic [MEM_WORDS_LOG2-1:0] rd_idx;
	logic                      accept;
	logic                      fire;

	assign accept = arvalid && arready;
	// delay elapsed, load the word into rdata
	assign fire = busy && !rvalid && (delay_cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			arready   <= 1'b0;
			rvalid    <= 1'b0;
			delay_cnt <= '0;
		end else if (accept) begin
			busy      <= 1'b1;
			arready   <= 1'b0;
			delay_cnt <= cnt_w'(RESP_DELAY);
		end else if (fire) begin
			rvalid <= 1'b1;
		end else if (busy && !rvalid) begin
			delay_cnt <= delay_cnt - 1'b1;
		end else if (rvalid && rready) begin
			rvalid  <= 1'b0;
			busy    <= 1'b0;
			arready <= 1'b1;
		end else if (!busy) begin
			arready <= 1'b1;
		end
	end

	// word index, upper address bits wrap
	always_ff @(posedge clk) begin
		if (accept)
			rd_idx <= araddr[MEM_WORDS_LOG2+1:2];
	end

	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_addr] <= load_data;
		if (fire)
			rdata <= mem[rd_idx];
	end

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
/* fetch front end top: fetch unit wired to the AXI-Lite instruction memory
   sets queue depth, byte order, memory size and response delay */
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
	parameter int QUEUE_DEPTH_LOG2 = 3,
	parameter int MEM_WORDS_LOG2   = 8,
	parameter int RESP_DELAY       = 2,
	parameter bit SWAP_BYTES       = 1'b1
) (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      go,
	input  wire fetch_pkg::addr_t          boot_pc,
	input  wire logic                      stall,
	input  wire logic                      flush,
	input  wire fetch_pkg::addr_t          redirect_pc,
	input  wire logic                      ecall_retired,

	// memory preload
	input  wire logic                      load_en,
	input  wire logic [MEM_WORDS_LOG2-1:0] load_addr,
	input  wire fetch_pkg::instr_t         load_data,

	output fetch_pkg::instr_t              instr,
	output fetch_pkg::addr_t               pc_out,
	output logic                           instr_valid
);

	import fetch_pkg::*;

	// AXI-Lite read channel between fetch and memory
	addr_t  araddr;
	logic   arvalid;
	logic   arready;
	instr_t rdata;
	logic   rvalid;
	logic   rready;

	fetch_unit #(
		.QUEUE_DEPTH_LOG2 (QUEUE_DEPTH_LOG2),
		.SWAP_BYTES       (SWAP_BYTES)
	) u_fetch (
		.clk           (clk),
		.rst_n         (rst_n),
		.go            (go),
		.boot_pc       (boot_pc),
		.stall         (stall),
		.flush         (flush),
		.redirect_pc   (redirect_pc),
		.ecall_retired (ecall_retired),
		.instr         (instr),
		.pc_out        (pc_out),
		.instr_valid   (instr_valid),
		.araddr        (araddr),
		.arvalid       (arvalid),
		.arready       (arready),
		.rdata         (rdata),
		.rvalid        (rvalid),
		.rready        (rready)
	);

	axil_instr_rom #(
		.MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
		.RESP_DELAY     (RESP_DELAY)
	) u_rom (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rvalid    (rvalid),
		.rready    (rready)
	);

endmodule

`default_nettype wire

// ==== tb_fetch.sv ====
/* testbench for the fetch front end: preloads the instruction memory,
   drives go, stall, flush and ecall retire, and checks every issued word */
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

	import fetch_pkg::*;

	localparam int    mem_words_log2 = 8;
	localparam int    max_cycles     = 5000;
	localparam addr_t boot_addr      = 32'h0000_0100;
	localparam addr_t ecall_addr     = 32'h0000_0200;

	logic                      clk;
	logic                      rst_n;
	logic                      go;
	addr_t                     boot_pc;
	logic                      stall;
	logic                      flush;
	addr_t                     redirect_pc;
	logic                      ecall_retired;
	logic                      load_en;
	logic [mem_words_log2-1:0] load_addr;
	instr_t                    load_data;
	instr_t                    instr;
	addr_t                     pc_out;
	logic                      instr_valid;

	// expected instruction per word, in issue byte order
	instr_t prog [1 << mem_words_log2];

	addr_t exp_pc;
	addr_t start_pc;
	addr_t last_pc;
	int    issued;
	int    checks;
	int    seq_checks;
	int    chk_errors;
	int    seq_errors;
	int    cycles;
	int    issued_at_start;
	int    errors_at_start;
	string test_name;

	fetch_top #(
		.MEM_WORDS_LOG2 (mem_words_log2)
	) uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.go            (go),
		.boot_pc       (boot_pc),
		.stall         (stall),
		.flush         (flush),
		.redirect_pc   (redirect_pc),
		.ecall_retired (ecall_retired),
		.load_en       (load_en),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.instr         (instr),
		.pc_out        (pc_out),
		.instr_valid   (instr_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run still going after %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// issue checker, expected pc follows the last issue, a flush or a start
	always @(posedge clk) begin
		if (rst_n) begin
			if (instr_valid) begin
				checks += 2;
				assert (pc_out == exp_pc) else begin
					$display("[FAIL] %s: pc expected %h, actual %h", test_name, exp_pc, pc_out);
					chk_errors++;
				end
				assert (instr == prog[pc_out[mem_words_log2+1:2]]) else begin
					$display("[FAIL] %s: instr at %h expected %h, actual %h", test_name,
						pc_out, prog[pc_out[mem_words_log2+1:2]], instr);
					chk_errors++;
				end
				issued++;
				last_pc = pc_out;
				exp_pc  = pc_out + 32'd4;
			end else begin
				checks++;
				assert (instr == nop_instr && pc_out == '0) else begin
					$display("[FAIL] %s: idle issue expected %h at pc 0, actual %h at pc %h",
						test_name, nop_instr, instr, pc_out);
					chk_errors++;
				end
			end
			assert (!(instr_valid && (stall || flush))) else begin
				$display("%s: an instruction was issued while stall or flush was high",
					test_name);
				chk_errors++;
			end
			if (flush)
				exp_pc = redirect_pc;
			else if (go)
				exp_pc = start_pc;
		end
	end

	// memory holds each word with its bytes reversed
	function automatic instr_t to_mem_order(input instr_t word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	task automatic wait_issues(input int n);
		int target;
		target = issued + n;
		while (issued < target)
			@(negedge clk);
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		issued_at_start = issued;
		errors_at_start = chk_errors + seq_errors;
	endtask

	task automatic end_test();
		$display("%s: %0d issues checked, %0d errors", test_name,
			issued - issued_at_start, chk_errors + seq_errors - errors_at_start);
	endtask

	task automatic write_word(input int idx, input instr_t word);
		prog[idx] = word;
		load_en   = 1'b1;
		load_addr = mem_words_log2'(idx);
		load_data = to_mem_order(word);
		@(negedge clk);
		load_en   = 1'b0;
	endtask

	task automatic pulse_go(input addr_t from_pc);
		start_pc = from_pc;
		go       = 1'b1;
		@(negedge clk);
		go       = 1'b0;
	endtask

	task automatic pulse_flush(input addr_t target);
		redirect_pc = target;
		flush       = 1'b1;
		@(negedge clk);
		flush       = 1'b0;
	endtask

	initial begin
		int                        i;
		int                        held;
		instr_t                    word;
		logic [mem_words_log2-1:0] idx;

		void'($urandom(32'h9e5d6216));
		rst_n         = 1'b0;
		go            = 1'b0;
		boot_pc       = boot_addr;
		stall         = 1'b0;
		flush         = 1'b0;
		redirect_pc   = '0;
		ecall_retired = 1'b0;
		load_en       = 1'b0;
		load_addr     = '0;
		load_data     = '0;
		start_pc      = boot_addr;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// random program, no ecall until the halt test places one
		start_test("reset_start");
		for (i = 0; i < (1 << mem_words_log2); i++) begin
			word = $urandom;
			if (word == ecall_instr)
				word = nop_instr;
			write_word(i, word);
		end
		seq_checks++;
		assert (issued == 0) else begin
			$display("%s: an instruction was issued before go", test_name);
			seq_errors++;
		end
		pulse_go(boot_addr);
		wait_issues(21);
		end_test();

		start_test("stall_random");
		repeat (200) begin
			stall = ($urandom_range(0, 2) == 0);
			@(negedge clk);
		end
		stall = 1'b0;
		wait_issues(4);
		end_test();

		// long stall lets the queue fill up to its threshold
		start_test("back_pressure");
		stall = 1'b1;
		repeat (100) @(negedge clk);
		stall = 1'b0;
		wait_issues(20);
		end_test();

		start_test("flush_redirect");
		for (i = 0; i < 8; i++) begin
			repeat ($urandom_range(0, 6)) @(negedge clk);
			// odd rounds hit a read in flight, even rounds a gap between reads
			while (uut.u_fetch.outstanding != i[0])
				@(negedge clk);
			idx = mem_words_log2'($urandom_range(0, (1 << mem_words_log2) - 1));
			pulse_flush(addr_t'(idx) << 2);
			wait_issues(3);
		end
		end_test();

		start_test("ecall_halt");
		stall = 1'b1;
		write_word(int'(ecall_addr[mem_words_log2+1:2]), ecall_instr);
		pulse_flush(ecall_addr - 32'd16);
		stall = 1'b0;
		wait_issues(5);
		seq_checks++;
		assert (last_pc == ecall_addr) else begin
			$display("[FAIL] %s: halt pc expected %h, actual %h", test_name, ecall_addr, last_pc);
			seq_errors++;
		end
		held = issued;
		repeat (50) @(negedge clk);
		seq_checks++;
		assert (issued == held) else begin
			$display("[FAIL] %s: issue count after ecall expected %0d, actual %0d",
				test_name, held, issued);
			seq_errors++;
		end
		ecall_retired = 1'b1;
		@(negedge clk);
		ecall_retired = 1'b0;
		@(negedge clk);
		pulse_go(ecall_addr + 32'd4);
		wait_issues(4);
		end_test();

		$display("tests: 5, checks: %0d, errors: %0d", checks + seq_checks,
			chk_errors + seq_errors);
		if (chk_errors + seq_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fetch_sys.f ====
fetch_pkg.sv
axil_read_master.sv
instr_queue.sv
fetch_unit.sv
axil_instr_rom.sv
fetch_top.sv
tb_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the fetch front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=tb_fetch_sim
log_file=sim.log

verilator --binary --timing --assert --top-module tb_fetch \
	-Mdir "$build_dir" -o "$sim_bin" -f fetch_sys.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST OK" "$log_file"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see $log_file"
exit 1
